/* hdl/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [3:0] reg_sel_t;

    localparam reg_sel_t REG_ZERO = 4'd0;
    localparam reg_sel_t REG_A = 4'd1;
    localparam reg_sel_t REG_J = 4'd10;
    localparam reg_sel_t REG_N = 4'd14;

    // Instruction word layout
    localparam int JMP_BIT = 31;
    localparam int RD_HI = 27;
    localparam int RD_LO = 24;
    localparam int ALU_HI = 23;
    localparam int ALU_LO = 21;
    localparam int RS_HI = 20;
    localparam int RS_LO = 17;
    localparam int IMM_BIT = 16;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;
    localparam int REP_BIT = 12;
    localparam int RT_HI = 11;
    localparam int RT_LO = 8;
    localparam int JOFS_HI = 7;
    localparam int JOFS_LO = 0;
    localparam int STORE_BIT = 2;
    localparam int LOAD_BIT = 1;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_OR = 3'd2,
        ALU_AND = 3'd3,
        ALU_XOR = 3'd4,
        ALU_RSV = 3'd5,
        ALU_CLAMP = 3'd6,
        ALU_MUL = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic valid;
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        alu_op_e alu;
        logic [31:0] imm;
        logic imm_en;
        logic load;
        logic store;
        logic repn;
    } dec_op_t;

    typedef struct packed {
        dec_op_t op;
        logic [31:0] sval;
        logic [31:0] tval;
    } rd_op_t;

    typedef struct packed {
        logic valid;
        reg_sel_t rd;
        logic [31:0] val;
    } wb_t;

    typedef struct packed {
        logic we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dbus_req_t;

endpackage

/* hdl/cpu_fetch.sv */
module cpu_fetch #(
    parameter int PC_W = 16
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            hold_i,
    input  logic            busy_i,
    input  logic            jump_i,
    input  logic [PC_W-1:0] jump_pc_i,
    output logic [PC_W-1:0] p_addr_o,
    input  logic [31:0]     p_data_i,
    output logic [31:0]     inst_o,
    output logic [PC_W-1:0] inst_pc_o,
    output logic            inst_valid_o
);

    logic [PC_W-1:0] pc;

    assign p_addr_o = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            inst_valid_o <= 1'b0;
        end else if (jump_i) begin
            // Word fetched behind the jump is thrown away
            pc <= jump_pc_i;
            inst_valid_o <= 1'b0;
        end else if (!hold_i && !busy_i) begin
            pc <= pc + 1'b1;
            inst_o <= p_data_i;
            inst_pc_o <= pc;
            inst_valid_o <= 1'b1;
        end
    end

endmodule

/* hdl/cpu_decode.sv */
module cpu_decode #(
    parameter int PC_W = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             hold_i,
    input  logic             busy_i,
    input  logic [31:0]      inst_i,
    input  logic [PC_W-1:0]  inst_pc_i,
    input  logic             inst_valid_i,
    output cpu_pkg::dec_op_t op_o,
    output logic             jump_o,
    output logic [PC_W-1:0]  jump_pc_o
);

    localparam int OFS_W = cpu_pkg::JOFS_HI - cpu_pkg::JOFS_LO + 1;

    logic             is_jump;
    logic             is_imm;
    logic [PC_W-1:0]  jump_ofs;
    cpu_pkg::dec_op_t dec;

    assign is_jump = inst_i[cpu_pkg::JMP_BIT];
    assign is_imm = inst_i[cpu_pkg::IMM_BIT];

    // Relative jumps are taken straight from the fetch register
    assign jump_ofs = {{(PC_W - OFS_W){inst_i[cpu_pkg::JOFS_HI]}},
                       inst_i[cpu_pkg::JOFS_HI:cpu_pkg::JOFS_LO]};
    assign jump_o = inst_valid_i && is_jump;
    assign jump_pc_o = inst_pc_i + jump_ofs;

    always_comb begin
        dec.valid = inst_valid_i && !is_jump;
        dec.rs = inst_i[cpu_pkg::RS_HI:cpu_pkg::RS_LO];
        dec.rt = inst_i[cpu_pkg::RT_HI:cpu_pkg::RT_LO];
        dec.rd = inst_i[cpu_pkg::RD_HI:cpu_pkg::RD_LO];
        dec.alu = cpu_pkg::alu_op_e'(inst_i[cpu_pkg::ALU_HI:cpu_pkg::ALU_LO]);
        dec.imm = {{16{inst_i[cpu_pkg::IMM_HI]}}, inst_i[cpu_pkg::IMM_HI:cpu_pkg::IMM_LO]};
        dec.imm_en = is_imm;
        // These bits overlap the immediate and the jump offset
        dec.load = !is_jump && !is_imm && inst_i[cpu_pkg::LOAD_BIT];
        dec.store = !is_jump && !is_imm && inst_i[cpu_pkg::STORE_BIT];
        dec.repn = !is_jump && !is_imm && inst_i[cpu_pkg::REP_BIT];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_o.valid <= 1'b0;
        end else if (!hold_i && !busy_i) begin
            op_o <= dec;
        end
    end

endmodule

/* hdl/cpu_regfile.sv */
module cpu_regfile (
    input  logic             clk,
    input  logic             rst,
    input  logic             busy_i,
    input  logic             issue_i,
    input  cpu_pkg::dec_op_t op_i,
    output cpu_pkg::rd_op_t  rd_op_o,
    input  cpu_pkg::wb_t     wb_i,
    output logic             n_zero_o
);

    logic [31:0] gpr [cpu_pkg::REG_A:cpu_pkg::REG_J];
    logic [31:0] n_ff;
    logic [31:0] n_next;
    logic        n_zero_ff;

    function automatic logic [31:0] read_reg(input cpu_pkg::reg_sel_t sel);
        logic [31:0] val;
        val = '0;
        if (sel >= cpu_pkg::REG_A && sel <= cpu_pkg::REG_J) begin
            val = gpr[sel];
        end else if (sel == cpu_pkg::REG_N) begin
            val = n_ff;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (wb_i.valid && wb_i.rd >= cpu_pkg::REG_A && wb_i.rd <= cpu_pkg::REG_J) begin
            gpr[wb_i.rd] <= wb_i.val;
        end
    end

    // Write-back wins over the repeat decrement
    always_comb begin
        n_next = n_ff;
        if (wb_i.valid && wb_i.rd == cpu_pkg::REG_N) begin
            n_next = wb_i.val;
        end else if (issue_i && op_i.repn && n_ff != '0) begin
            n_next = n_ff - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            n_ff <= '0;
            n_zero_ff <= 1'b1;
        end else begin
            n_ff <= n_next;
            n_zero_ff <= (n_next == '0);
        end
    end

    assign n_zero_o = n_zero_ff;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_op_o.op.valid <= 1'b0;
        end else if (!busy_i) begin
            if (issue_i) begin
                rd_op_o.op <= op_i;
                rd_op_o.sval <= read_reg(op_i.rs);
                rd_op_o.tval <= read_reg(op_i.rt);
            end else begin
                rd_op_o.op.valid <= 1'b0;
            end
        end
    end

endmodule

/* hdl/cpu_sequencer.sv */
module cpu_sequencer (
    input  cpu_pkg::dec_op_t op_i,
    input  cpu_pkg::rd_op_t  rd_stage_i,
    input  cpu_pkg::rd_op_t  mem_stage_i,
    input  cpu_pkg::wb_t     wb_i,
    input  logic             n_zero_i,
    input  logic             busy_i,
    output logic             hold_o,
    output logic             issue_o
);

    logic hazard;
    logic rep_hold;

    function automatic logic writes(input cpu_pkg::dec_op_t op, input cpu_pkg::reg_sel_t sel);
        return op.valid && !op.store && op.rd != cpu_pkg::REG_ZERO && op.rd == sel;
    endfunction

    // Any in-flight producer of sel still ahead of the register write
    function automatic logic pending(input cpu_pkg::reg_sel_t sel);
        logic hit;
        hit = writes(rd_stage_i.op, sel) || writes(mem_stage_i.op, sel);
        hit = hit || (wb_i.valid && wb_i.rd == sel);
        return hit;
    endfunction

    always_comb begin
        hazard = 1'b0;
        if (op_i.valid) begin
            hazard = pending(op_i.rs);
            if (!op_i.imm_en) begin
                hazard = hazard || pending(op_i.rt);
            end
            // Repeat count must be settled before it is tested
            if (op_i.repn) begin
                hazard = hazard || pending(cpu_pkg::REG_N);
            end
        end
    end

    assign rep_hold = op_i.valid && op_i.repn && !n_zero_i;
    assign hold_o = hazard || rep_hold;
    assign issue_o = op_i.valid && !hazard && !busy_i;

endmodule

/* hdl/cpu_mem.sv */
module cpu_mem (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::rd_op_t    op_i,
    output cpu_pkg::rd_op_t    op_o,
    output logic               busy_o,
    output cpu_pkg::dbus_req_t dbus_o,
    output logic               dbus_req_o,
    input  logic               dbus_ack_i,
    input  logic [31:0]        dbus_rdata_i
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE
    } state_e;

    state_e      state;
    logic [31:0] rdata_ff;
    logic        access;
    logic        done;

    assign access = op_i.op.valid && (op_i.op.load || op_i.op.store);
    // Transfer ends once the slave has dropped ack
    assign done = (state == RELEASE) && !dbus_ack_i;
    assign busy_o = access && !done;

    assign dbus_req_o = (state == REQ);

    always_comb begin
        dbus_o.we = op_i.op.store;
        dbus_o.addr = op_i.sval;
        dbus_o.wdata = op_i.tval;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (access) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (dbus_ack_i) begin
                        state <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!dbus_ack_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == REQ && dbus_ack_i) begin
            rdata_ff <= dbus_rdata_i;
        end
    end

    always_comb begin
        op_o = op_i;
        if (op_i.op.imm_en) begin
            op_o.tval = op_i.op.imm;
        end
        if (access) begin
            op_o.op.valid = done;
            if (op_i.op.load) begin
                op_o.sval = rdata_ff;
            end
        end
    end

endmodule

/* hdl/cpu_execute.sv */
module cpu_execute (
    input  logic            clk,
    input  logic            rst,
    input  cpu_pkg::rd_op_t op_i,
    output cpu_pkg::wb_t    wb_o
);

    logic [31:0] result;
    logic [31:0] s;
    logic [31:0] t;

    assign s = op_i.sval;
    assign t = op_i.tval;

    always_comb begin
        result = '0;
        case (op_i.op.alu)
            cpu_pkg::ALU_ADD: result = s + t;
            cpu_pkg::ALU_SUB: result = s - t;
            cpu_pkg::ALU_OR: result = s | t;
            cpu_pkg::ALU_AND: result = s & t;
            cpu_pkg::ALU_XOR: result = s ^ t;
            cpu_pkg::ALU_RSV: result = '0;
            cpu_pkg::ALU_CLAMP: begin
                // Saturate to a signed 16-bit range
                if ($signed(s) > 32'sd32767) begin
                    result = 32'h0000_7fff;
                end else if ($signed(s) < -32'sd32768) begin
                    result = 32'hffff_8000;
                end else begin
                    result = s;
                end
            end
            cpu_pkg::ALU_MUL: result = s * t;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid <= op_i.op.valid && !op_i.op.store && op_i.op.rd != cpu_pkg::REG_ZERO;
            wb_o.rd <= op_i.op.rd;
            wb_o.val <= result;
        end
    end

endmodule

/* hdl/cpu_top.sv */
module cpu_top #(
    parameter int PC_W = 16
) (
    input  logic               clk,
    input  logic               rst,
    output logic [PC_W-1:0]    p_addr_o,
    input  logic [31:0]        p_data_i,
    output cpu_pkg::dbus_req_t dbus_o,
    output logic               dbus_req_o,
    input  logic               dbus_ack_i,
    input  logic [31:0]        dbus_rdata_i
);

    logic [31:0]      if_inst;
    logic [PC_W-1:0]  if_inst_pc;
    logic             if_inst_valid;
    cpu_pkg::dec_op_t dec_op;
    logic             dec_jump;
    logic [PC_W-1:0]  dec_jump_pc;
    logic             seq_hold;
    logic             seq_issue;
    cpu_pkg::rd_op_t  rf_rd_op;
    logic             rf_n_zero;
    cpu_pkg::rd_op_t  mem_op;
    logic             mem_busy;
    cpu_pkg::wb_t     ex_wb;

    cpu_fetch #(
        .PC_W(PC_W)
    ) u_fetch (
        .clk(clk),
        .rst(rst),
        .hold_i(seq_hold),
        .busy_i(mem_busy),
        .jump_i(dec_jump),
        .jump_pc_i(dec_jump_pc),
        .p_addr_o(p_addr_o),
        .p_data_i(p_data_i),
        .inst_o(if_inst),
        .inst_pc_o(if_inst_pc),
        .inst_valid_o(if_inst_valid)
    );

    cpu_decode #(
        .PC_W(PC_W)
    ) u_decode (
        .clk(clk),
        .rst(rst),
        .hold_i(seq_hold),
        .busy_i(mem_busy),
        .inst_i(if_inst),
        .inst_pc_i(if_inst_pc),
        .inst_valid_i(if_inst_valid),
        .op_o(dec_op),
        .jump_o(dec_jump),
        .jump_pc_o(dec_jump_pc)
    );

    cpu_sequencer u_sequencer (
        .op_i(dec_op),
        .rd_stage_i(rf_rd_op),
        .mem_stage_i(mem_op),
        .wb_i(ex_wb),
        .n_zero_i(rf_n_zero),
        .busy_i(mem_busy),
        .hold_o(seq_hold),
        .issue_o(seq_issue)
    );

    cpu_regfile u_regfile (
        .clk(clk),
        .rst(rst),
        .busy_i(mem_busy),
        .issue_i(seq_issue),
        .op_i(dec_op),
        .rd_op_o(rf_rd_op),
        .wb_i(ex_wb),
        .n_zero_o(rf_n_zero)
    );

    cpu_mem u_mem (
        .clk(clk),
        .rst(rst),
        .op_i(rf_rd_op),
        .op_o(mem_op),
        .busy_o(mem_busy),
        .dbus_o(dbus_o),
        .dbus_req_o(dbus_req_o),
        .dbus_ack_i(dbus_ack_i),
        .dbus_rdata_i(dbus_rdata_i)
    );

    cpu_execute u_execute (
        .clk(clk),
        .rst(rst),
        .op_i(mem_op),
        .wb_o(ex_wb)
    );

endmodule

/* test/cpu_top_tb.sv */
module cpu_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PC_W = 16;
    localparam int NUM_TESTS = 5;
    localparam int PMEM_SIZE = 256;
    localparam logic [31:0] HALT = 32'h8000_0000;
    localparam logic [31:0] LOAD_MASK = 32'h5a5a_0000;

    // Register selectors a to j and n
    localparam logic [3:0] RA = 4'd1;
    localparam logic [3:0] RB = 4'd2;
    localparam logic [3:0] RC = 4'd3;
    localparam logic [3:0] RE = 4'd5;
    localparam logic [3:0] RJ = 4'd10;
    localparam logic [3:0] RN = 4'd14;

    logic               clk;
    logic               rst;
    logic [PC_W-1:0]    p_addr_o;
    logic [31:0]        p_data_i;
    cpu_pkg::dbus_req_t dbus;
    logic               dbus_req_o;
    logic               dbus_ack_i;
    logic [31:0]        dbus_rdata_i;

    logic [31:0] rom [0:127];
    logic [31:0] prog_mem [0:PMEM_SIZE-1];
    int          rom_ptr;

    string       test_name [NUM_TESTS];
    int          prog_start [NUM_TESTS];
    int          prog_len [NUM_TESTS];
    int          n_stores [NUM_TESTS];
    int          exp_first [NUM_TESTS];
    logic [31:0] exp_addr [0:31];
    logic [31:0] exp_data [0:31];
    int          test_cnt;
    int          exp_cnt;

    logic [31:0] st_addr_q [$];
    logic [31:0] st_data_q [$];
    integer      seed = 32'h56e0_fc82;
    int          ack_delay;
    int          wd_cycles;

    cpu_top #(
        .PC_W(PC_W)
    ) u_cpu_top (
        .clk(clk),
        .rst(rst),
        .p_addr_o(p_addr_o),
        .p_data_i(p_data_i),
        .dbus_o(dbus),
        .dbus_req_o(dbus_req_o),
        .dbus_ack_i(dbus_ack_i),
        .dbus_rdata_i(dbus_rdata_i)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    assign p_data_i = (p_addr_o < PMEM_SIZE) ? prog_mem[p_addr_o[7:0]] : HALT;

    function automatic logic [31:0] op_imm(input logic [3:0] rd, input logic [2:0] alu,
                                           input logic [3:0] rs, input logic [15:0] imm);
        logic [31:0] w;
        w = '0;
        w[27:24] = rd;
        w[23:21] = alu;
        w[20:17] = rs;
        w[16] = 1'b1;
        w[15:0] = imm;
        return w;
    endfunction

    function automatic logic [31:0] op_reg(input logic [3:0] rd, input logic [2:0] alu,
                                           input logic [3:0] rs, input logic [3:0] rt,
                                           input logic rep, input logic load);
        logic [31:0] w;
        w = '0;
        w[27:24] = rd;
        w[23:21] = alu;
        w[20:17] = rs;
        w[12] = rep;
        w[11:8] = rt;
        w[1] = load;
        return w;
    endfunction

    function automatic logic [31:0] op_store(input logic [3:0] addr_reg,
                                             input logic [3:0] data_reg);
        logic [31:0] w;
        w = '0;
        w[20:17] = addr_reg;
        w[11:8] = data_reg;
        w[2] = 1'b1;
        return w;
    endfunction

    function automatic logic [31:0] op_jump(input logic [7:0] ofs);
        logic [31:0] w;
        w = '0;
        w[31] = 1'b1;
        w[7:0] = ofs;
        return w;
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[rom_ptr] = w;
        rom_ptr++;
    endtask

    task automatic begin_test(input string name, input int stores);
        test_name[test_cnt] = name;
        prog_start[test_cnt] = rom_ptr;
        n_stores[test_cnt] = stores;
        exp_first[test_cnt] = exp_cnt;
    endtask

    task automatic end_test();
        prog_len[test_cnt] = rom_ptr - prog_start[test_cnt];
        test_cnt++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr[exp_cnt] = addr;
        exp_data[exp_cnt] = data;
        exp_cnt++;
    endtask

    // c = a op b, store c at j, then step j
    task automatic alu_and_store(input logic [2:0] alu);
        emit(op_reg(RC, alu, RA, RB, 1'b0, 1'b0));
        emit(op_store(RJ, RC));
        emit(op_imm(RJ, cpu_pkg::ALU_ADD, RJ, 16'd4));
    endtask

    task automatic build_tests();
        rom_ptr = 0;
        test_cnt = 0;
        exp_cnt = 0;

        begin_test("alu", 9);
        emit(op_imm(RA, cpu_pkg::ALU_ADD, 4'd0, 16'h1234));
        emit(op_imm(RB, cpu_pkg::ALU_ADD, 4'd0, 16'h0ff0));
        emit(op_imm(RJ, cpu_pkg::ALU_ADD, 4'd0, 16'h0100));
        alu_and_store(cpu_pkg::ALU_ADD);
        alu_and_store(cpu_pkg::ALU_SUB);
        alu_and_store(cpu_pkg::ALU_OR);
        alu_and_store(cpu_pkg::ALU_AND);
        alu_and_store(cpu_pkg::ALU_XOR);
        alu_and_store(cpu_pkg::ALU_RSV);
        alu_and_store(cpu_pkg::ALU_MUL);
        // Clamp the large product, then a value below -32768
        emit(op_reg(RC, cpu_pkg::ALU_CLAMP, RC, 4'd0, 1'b0, 1'b0));
        emit(op_store(RJ, RC));
        emit(op_imm(RJ, cpu_pkg::ALU_ADD, RJ, 16'd4));
        emit(op_imm(RE, cpu_pkg::ALU_ADD, 4'd0, 16'h8000));
        emit(op_reg(RE, cpu_pkg::ALU_ADD, RE, RE, 1'b0, 1'b0));
        emit(op_reg(RC, cpu_pkg::ALU_CLAMP, RE, 4'd0, 1'b0, 1'b0));
        emit(op_store(RJ, RC));
        emit(op_jump(8'd0));
        expect_store(32'h100, 32'h0000_2224);
        expect_store(32'h104, 32'h0000_0244);
        expect_store(32'h108, 32'h0000_1ff4);
        expect_store(32'h10c, 32'h0000_0230);
        expect_store(32'h110, 32'h0000_1dc4);
        expect_store(32'h114, 32'h0000_0000);
        expect_store(32'h118, 32'h0122_1cc0);
        expect_store(32'h11c, 32'h0000_7fff);
        expect_store(32'h120, 32'hffff_8000);
        end_test();

        begin_test("interlock", 1);
        emit(op_imm(RA, cpu_pkg::ALU_ADD, 4'd0, 16'd1));
        emit(op_imm(RA, cpu_pkg::ALU_ADD, RA, 16'd1));
        emit(op_imm(RA, cpu_pkg::ALU_ADD, RA, 16'd1));
        emit(op_imm(RA, cpu_pkg::ALU_ADD, RA, 16'd1));
        emit(op_imm(RJ, cpu_pkg::ALU_ADD, 4'd0, 16'h0200));
        emit(op_store(RJ, RA));
        emit(op_jump(8'd0));
        expect_store(32'h200, 32'd4);
        end_test();

        begin_test("load", 1);
        emit(op_imm(RA, cpu_pkg::ALU_ADD, 4'd0, 16'h0040));
        emit(op_imm(RB, cpu_pkg::ALU_ADD, 4'd0, 16'd5));
        emit(op_reg(RC, cpu_pkg::ALU_ADD, RA, RB, 1'b0, 1'b1));
        emit(op_imm(RJ, cpu_pkg::ALU_ADD, 4'd0, 16'h0300));
        emit(op_store(RJ, RC));
        emit(op_jump(8'd0));
        expect_store(32'h300, 32'h5a5a_0045);
        end_test();

        begin_test("repeat", 2);
        emit(op_imm(RN, cpu_pkg::ALU_ADD, 4'd0, 16'd4));
        emit(op_imm(RA, cpu_pkg::ALU_ADD, 4'd0, 16'd0));
        emit(op_imm(RB, cpu_pkg::ALU_ADD, 4'd0, 16'd3));
        emit(op_reg(RA, cpu_pkg::ALU_ADD, RA, RB, 1'b1, 1'b0));
        emit(op_imm(RJ, cpu_pkg::ALU_ADD, 4'd0, 16'h0400));
        emit(op_store(RJ, RA));
        emit(op_imm(RJ, cpu_pkg::ALU_ADD, RJ, 16'd4));
        emit(op_store(RJ, RN));
        emit(op_jump(8'd0));
        expect_store(32'h400, 32'd15);
        expect_store(32'h404, 32'd0);
        end_test();

        begin_test("jump", 2);
        emit(op_imm(RJ, cpu_pkg::ALU_ADD, 4'd0, 16'h0500));
        emit(op_imm(RA, cpu_pkg::ALU_ADD, 4'd0, 16'h0011));
        emit(op_store(RJ, RA));
        emit(op_jump(8'd2));
        emit(op_store(RJ, RA));
        emit(op_imm(RB, cpu_pkg::ALU_ADD, 4'd0, 16'h0022));
        emit(op_imm(RJ, cpu_pkg::ALU_ADD, RJ, 16'd4));
        emit(op_store(RJ, RB));
        emit(op_jump(8'd0));
        expect_store(32'h500, 32'h0000_0011);
        expect_store(32'h504, 32'h0000_0022);
        end_test();
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic run_test(input int t);
        int k;
        @(negedge clk);
        rst = 1'b1;
        st_addr_q.delete();
        st_data_q.delete();
        for (int i = 0; i < PMEM_SIZE; i++) begin
            prog_mem[i] = (i < prog_len[t]) ? rom[prog_start[t] + i] : HALT;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check({test_name[t], " req after reset"}, 32'd0, {31'd0, dbus_req_o});
        check({test_name[t], " pc after reset"}, 32'd0, {16'd0, p_addr_o});
        while (st_addr_q.size() < n_stores[t]) begin
            @(negedge clk);
        end
        // Watch for stray stores past the halt
        repeat (50) @(negedge clk);
        check({test_name[t], " store count"}, n_stores[t], st_addr_q.size());
        for (int s = 0; s < n_stores[t]; s++) begin
            k = exp_first[t] + s;
            check({test_name[t], " store addr"}, exp_addr[k], st_addr_q[s]);
            check({test_name[t], " store data"}, exp_data[k], st_data_q[s]);
        end
    endtask

    // Data memory with a random ack delay
    initial begin
        dbus_ack_i = 1'b0;
        dbus_rdata_i = '0;
        forever begin
            @(negedge clk);
            if (rst) begin
                dbus_ack_i = 1'b0;
            end else if (dbus_req_o && !dbus_ack_i) begin
                ack_delay = $random(seed) & 3;
                repeat (ack_delay) @(negedge clk);
                if (dbus.we) begin
                    st_addr_q.push_back(dbus.addr);
                    st_data_q.push_back(dbus.wdata);
                end
                dbus_rdata_i = dbus.addr ^ LOAD_MASK;
                dbus_ack_i = 1'b1;
            end else if (!dbus_req_o && dbus_ack_i) begin
                dbus_ack_i = 1'b0;
            end
        end
    end

    initial begin
        rst = 1'b1;
        for (int i = 0; i < PMEM_SIZE; i++) begin
            prog_mem[i] = HALT;
        end
        build_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("TEST OK");
        $finish;
    end

    initial begin
        #1;
        wd_cycles = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            wd_cycles += prog_len[t] * 20 + 100;
        end
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: the stores did not arrive within %0d cycles", wd_cycles);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

/* cpu_top.f */
hdl/cpu_pkg.sv
hdl/cpu_fetch.sv
hdl/cpu_decode.sv
hdl/cpu_regfile.sv
hdl/cpu_sequencer.sv
hdl/cpu_mem.sv
hdl/cpu_execute.sv
hdl/cpu_top.sv
test/cpu_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cpu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f cpu_top.f --top-module cpu_top_tb -o cpu_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpu_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
